//--- hdl/periph_defines.svh
/*
  Peripheral subsystem constants: bus window, pin and line counts,
  and the numbering of interrupt sources
*/
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Upper address half of the peripheral window
`define PERIPH_BASE_HI 16'h2000

`define PERIPH_GPIO_W 16
`define PERIPH_NEXT_INT 8

// Interrupt sources, id 0 reserved
`define PERIPH_NSRC 32
`define PERIPH_ID_W 5

`define PERIPH_SRC_GPIO 1
`define PERIPH_SRC_TIMER 17
`define PERIPH_SRC_EXT 18

`endif

//--- hdl/periph_pkg.sv
/*
  Peripheral subsystem types: controller states, block select
  and register offsets of each block
*/
`default_nettype none

package periph_pkg;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_ACCESS = 2'd1,
    ST_RESP   = 2'd2
  } ctrl_state_e;

  typedef enum logic [1:0] {
    SEL_GPIO  = 2'd0,
    SEL_TIMER = 2'd1,
    SEL_INTC  = 2'd2,
    SEL_NONE  = 2'd3
  } periph_sel_e;

  // Word offsets from address bits 3:2
  typedef enum logic [1:0] {
    GPIO_IN  = 2'd0,
    GPIO_OUT = 2'd1,
    GPIO_OEN = 2'd2,
    GPIO_IEN = 2'd3
  } gpio_reg_e;

  typedef enum logic [1:0] {
    TMR_COUNT = 2'd0,
    TMR_CMP   = 2'd1,
    TMR_CTRL  = 2'd2
  } timer_reg_e;

  typedef enum logic [1:0] {
    INTC_PEND  = 2'd0,
    INTC_EN    = 2'd1,
    INTC_CLAIM = 2'd2,
    INTC_MSIP  = 2'd3
  } intc_reg_e;

endpackage

`default_nettype wire

//--- hdl/periph_bus_ctrl.sv
/*
  Bus slave controller: grants one request at a time, decodes the target
  block, strobes its register port and returns the read data
*/
`default_nettype none
`include "periph_defines.svh"

module periph_bus_ctrl (
  input  wire         clk_i,
  input  wire         reset_i,
  input  wire         req_i,
  input  wire  [31:0] addr_i,
  input  wire         we_i,
  input  wire  [3:0]  be_i,
  input  wire  [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        gpio_sel_o,
  output logic        tmr_sel_o,
  output logic        intc_sel_o,
  output logic        reg_we_o,
  output logic [1:0]  reg_off_o,
  output logic [31:0] reg_wdata_o,
  output logic [3:0]  reg_be_o,
  input  wire  [31:0] gpio_rdata_i,
  input  wire  [31:0] tmr_rdata_i,
  input  wire  [31:0] intc_rdata_i
);

  periph_pkg::ctrl_state_e state_q;
  periph_pkg::periph_sel_e sel_d;
  periph_pkg::periph_sel_e sel_q;
  logic                    we_q;
  logic [1:0]              off_q;
  logic [31:0]             wdata_q;
  logic [3:0]              be_q;
  logic [31:0]             rdata_d;
  logic [31:0]             rdata_q;

  assign gnt_o = (state_q == periph_pkg::ST_IDLE) && req_i;

  // Address decode
  always_comb begin
    sel_d = periph_pkg::SEL_NONE;
    if (addr_i[31:16] == `PERIPH_BASE_HI) begin
      case (addr_i[15:12])
        4'd0:    sel_d = periph_pkg::SEL_GPIO;
        4'd1:    sel_d = periph_pkg::SEL_TIMER;
        4'd2:    sel_d = periph_pkg::SEL_INTC;
        default: sel_d = periph_pkg::SEL_NONE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= periph_pkg::ST_IDLE;
    end else begin
      case (state_q)
        periph_pkg::ST_IDLE:   if (gnt_o) state_q <= periph_pkg::ST_ACCESS;
        periph_pkg::ST_ACCESS: state_q <= periph_pkg::ST_RESP;
        default:               state_q <= periph_pkg::ST_IDLE;
      endcase
    end
  end

  // Request held for the access cycle
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      sel_q   <= sel_d;
      we_q    <= we_i;
      off_q   <= addr_i[3:2];
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
  end

  assign gpio_sel_o  = (state_q == periph_pkg::ST_ACCESS) && (sel_q == periph_pkg::SEL_GPIO);
  assign tmr_sel_o   = (state_q == periph_pkg::ST_ACCESS) && (sel_q == periph_pkg::SEL_TIMER);
  assign intc_sel_o  = (state_q == periph_pkg::ST_ACCESS) && (sel_q == periph_pkg::SEL_INTC);
  assign reg_we_o    = we_q;
  assign reg_off_o   = off_q;
  assign reg_wdata_o = wdata_q;
  assign reg_be_o    = be_q;

  // Writes and unmapped reads return zero
  always_comb begin
    case (sel_q)
      periph_pkg::SEL_GPIO:  rdata_d = gpio_rdata_i;
      periph_pkg::SEL_TIMER: rdata_d = tmr_rdata_i;
      periph_pkg::SEL_INTC:  rdata_d = intc_rdata_i;
      default:               rdata_d = '0;
    endcase
    if (we_q) rdata_d = '0;
  end

  always_ff @(posedge clk_i) begin
    if (state_q == periph_pkg::ST_ACCESS) rdata_q <= rdata_d;
  end

  assign rvalid_o = (state_q == periph_pkg::ST_RESP);
  assign rdata_o  = rdata_q;

  gnt_rvalid_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(gnt_o && rvalid_o));

  // At most one block is addressed per access
  sel_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({gpio_sel_o, tmr_sel_o, intc_sel_o}));

endmodule

`default_nettype wire

//--- hdl/periph_gpio.sv
/*
  GPIO block: output and output-enable registers, synchronized inputs
  and per-pin rising-edge interrupt pulses
*/
`default_nettype none
`include "periph_defines.svh"

module periph_gpio (
  input  wire                         clk_i,
  input  wire                         reset_i,
  input  wire                         sel_i,
  input  wire                         we_i,
  input  wire  [1:0]                  off_i,
  input  wire  [31:0]                 wdata_i,
  input  wire  [3:0]                  be_i,
  output logic [31:0]                 rdata_o,
  input  wire  [`PERIPH_GPIO_W-1:0]   gpio_i,
  output logic [`PERIPH_GPIO_W-1:0]   gpio_o,
  output logic [`PERIPH_GPIO_W-1:0]   gpio_oe_o,
  output logic [`PERIPH_GPIO_W-1:0]   intr_o
);

  localparam int NBYTE = `PERIPH_GPIO_W / 8;

  periph_pkg::gpio_reg_e     off;
  logic [`PERIPH_GPIO_W-1:0] sync1_q;
  logic [`PERIPH_GPIO_W-1:0] sync2_q;
  logic [`PERIPH_GPIO_W-1:0] prev_q;
  logic [`PERIPH_GPIO_W-1:0] out_q;
  logic [`PERIPH_GPIO_W-1:0] oen_q;
  logic [`PERIPH_GPIO_W-1:0] ien_q;

  assign off = periph_pkg::gpio_reg_e'(off_i);

  // Two-stage synchronizer plus edge history
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign intr_o = sync2_q & ~prev_q & ien_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q <= '0;
      oen_q <= '0;
      ien_q <= '0;
    end else if (sel_i && we_i) begin
      for (int b = 0; b < NBYTE; b++) begin
        if (be_i[b]) begin
          case (off)
            periph_pkg::GPIO_OUT: out_q[8*b +: 8] <= wdata_i[8*b +: 8];
            periph_pkg::GPIO_OEN: oen_q[8*b +: 8] <= wdata_i[8*b +: 8];
            periph_pkg::GPIO_IEN: ien_q[8*b +: 8] <= wdata_i[8*b +: 8];
            default: ;
          endcase
        end
      end
    end
  end

  always_comb begin
    case (off)
      periph_pkg::GPIO_IN:  rdata_o = 32'(sync2_q);
      periph_pkg::GPIO_OUT: rdata_o = 32'(out_q);
      periph_pkg::GPIO_OEN: rdata_o = 32'(oen_q);
      default:              rdata_o = 32'(ien_q);
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oen_q;

endmodule

`default_nettype wire

//--- hdl/periph_timer.sv
/*
  Compare timer: free-running counter that wraps to zero on a
  compare match and pulses its interrupt line
*/
`default_nettype none

module periph_timer (
  input  wire         clk_i,
  input  wire         reset_i,
  input  wire         sel_i,
  input  wire         we_i,
  input  wire  [1:0]  off_i,
  input  wire  [31:0] wdata_i,
  input  wire  [3:0]  be_i,
  output logic [31:0] rdata_o,
  output logic        intr_o
);

  periph_pkg::timer_reg_e off;
  logic [31:0]            count_q;
  logic [31:0]            cmp_q;
  logic                   en_q;
  logic                   match;
  logic                   wr;

  assign off   = periph_pkg::timer_reg_e'(off_i);
  assign wr    = sel_i && we_i;
  assign match = en_q && (count_q == cmp_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
      cmp_q   <= '0;
      en_q    <= 1'b0;
      intr_o  <= 1'b0;
    end else begin
      intr_o <= match;
      // Software write to the count wins over counting
      if (wr && off == periph_pkg::TMR_COUNT) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) count_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end else if (match) begin
        count_q <= '0;
      end else if (en_q) begin
        count_q <= count_q + 32'd1;
      end
      if (wr && off == periph_pkg::TMR_CMP) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) cmp_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      if (wr && off == periph_pkg::TMR_CTRL && be_i[0]) en_q <= wdata_i[0];
    end
  end

  always_comb begin
    case (off)
      periph_pkg::TMR_COUNT: rdata_o = count_q;
      periph_pkg::TMR_CMP:   rdata_o = cmp_q;
      periph_pkg::TMR_CTRL:  rdata_o = {31'b0, en_q};
      default:               rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/periph_intc.sv
/*
  Interrupt controller: edge-latched pending bits, enables,
  lowest-id claim and a software interrupt bit
*/
`default_nettype none
`include "periph_defines.svh"

module periph_intc (
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire                      sel_i,
  input  wire                      we_i,
  input  wire  [1:0]               off_i,
  input  wire  [31:0]              wdata_i,
  input  wire  [3:0]               be_i,
  output logic [31:0]              rdata_o,
  input  wire  [`PERIPH_NSRC-1:0]  src_i,
  output logic                     irq_o,
  output logic                     msip_o
);

  periph_pkg::intc_reg_e   off;
  logic [`PERIPH_NSRC-1:0] src_q;
  logic [`PERIPH_NSRC-1:0] pend_q;
  logic [`PERIPH_NSRC-1:0] en_q;
  logic [`PERIPH_NSRC-1:0] active;
  logic [`PERIPH_NSRC-1:0] edge_set;
  logic [`PERIPH_NSRC-1:0] claim_clr;
  logic [`PERIPH_ID_W-1:0] claim_id;
  logic                    claim_rd;
  logic                    msip_q;

  assign off = periph_pkg::intc_reg_e'(off_i);

  // Id 0 never latches
  assign edge_set = src_i & ~src_q & {{(`PERIPH_NSRC-1){1'b1}}, 1'b0};
  assign active   = pend_q & en_q;
  assign irq_o    = |active;
  assign msip_o   = msip_q;

  // Lowest active id wins
  always_comb begin
    claim_id = '0;
    for (int i = `PERIPH_NSRC - 1; i > 0; i--) begin
      if (active[i]) claim_id = `PERIPH_ID_W'(i);
    end
  end

  assign claim_rd  = sel_i && !we_i && (off == periph_pkg::INTC_CLAIM);
  assign claim_clr = claim_rd ? (`PERIPH_NSRC'(1) << claim_id) : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      src_q  <= '0;
      pend_q <= '0;
      en_q   <= '0;
      msip_q <= 1'b0;
    end else begin
      src_q  <= src_i;
      // A new edge on the claimed id keeps it pending
      pend_q <= (pend_q & ~claim_clr) | edge_set;
      if (sel_i && we_i && off == periph_pkg::INTC_EN) begin
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) en_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      if (sel_i && we_i && off == periph_pkg::INTC_MSIP && be_i[0]) msip_q <= wdata_i[0];
    end
  end

  always_comb begin
    case (off)
      periph_pkg::INTC_PEND:  rdata_o = 32'(pend_q);
      periph_pkg::INTC_EN:    rdata_o = 32'(en_q);
      periph_pkg::INTC_CLAIM: rdata_o = 32'(claim_id);
      default:                rdata_o = {31'b0, msip_q};
    endcase
  end

  claim_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
    (claim_rd && irq_o) |-> (claim_id != '0));

endmodule

`default_nettype wire

//--- hdl/peripheral_subsystem.sv
/*
  Peripheral subsystem top: bus controller, GPIO, timer and
  interrupt controller with the interrupt source vector
*/
`default_nettype none
`include "periph_defines.svh"

module peripheral_subsystem (
  input  wire                         clk_i,
  input  wire                         reset_i,
  input  wire                         req_i,
  input  wire  [31:0]                 addr_i,
  input  wire                         we_i,
  input  wire  [3:0]                  be_i,
  input  wire  [31:0]                 wdata_i,
  output logic                        gnt_o,
  output logic                        rvalid_o,
  output logic [31:0]                 rdata_o,
  input  wire  [`PERIPH_GPIO_W-1:0]   gpio_i,
  output logic [`PERIPH_GPIO_W-1:0]   gpio_o,
  output logic [`PERIPH_GPIO_W-1:0]   gpio_oe_o,
  input  wire  [`PERIPH_NEXT_INT-1:0] ext_intr_i,
  output logic                        irq_o,
  output logic                        msip_o
);

  localparam int NPAD = `PERIPH_NSRC - `PERIPH_SRC_EXT - `PERIPH_NEXT_INT;

  logic                      gpio_sel;
  logic                      tmr_sel;
  logic                      intc_sel;
  logic                      reg_we;
  logic [1:0]                reg_off;
  logic [31:0]               reg_wdata;
  logic [3:0]                reg_be;
  logic [31:0]               gpio_rdata;
  logic [31:0]               tmr_rdata;
  logic [31:0]               intc_rdata;
  logic [`PERIPH_GPIO_W-1:0] gpio_intr;
  logic                      tmr_intr;
  logic [`PERIPH_NSRC-1:0]   intr_src;

  // Id 0 is reserved and tied low
  assign intr_src[0]                                       = 1'b0;
  assign intr_src[`PERIPH_SRC_GPIO +: `PERIPH_GPIO_W]      = gpio_intr;
  assign intr_src[`PERIPH_SRC_TIMER]                       = tmr_intr;
  assign intr_src[`PERIPH_SRC_EXT +: `PERIPH_NEXT_INT]     = ext_intr_i;
  assign intr_src[`PERIPH_NSRC-1 -: NPAD]                  = '0;

  periph_bus_ctrl ctrl_i (
    .clk_i, .reset_i, .req_i, .addr_i, .we_i, .be_i, .wdata_i,
    .gnt_o, .rvalid_o, .rdata_o,
    .gpio_sel_o(gpio_sel), .tmr_sel_o(tmr_sel), .intc_sel_o(intc_sel),
    .reg_we_o(reg_we), .reg_off_o(reg_off), .reg_wdata_o(reg_wdata), .reg_be_o(reg_be),
    .gpio_rdata_i(gpio_rdata), .tmr_rdata_i(tmr_rdata), .intc_rdata_i(intc_rdata)
  );

  periph_gpio gpio_u (
    .clk_i, .reset_i, .sel_i(gpio_sel), .we_i(reg_we), .off_i(reg_off),
    .wdata_i(reg_wdata), .be_i(reg_be), .rdata_o(gpio_rdata),
    .gpio_i, .gpio_o, .gpio_oe_o, .intr_o(gpio_intr)
  );

  periph_timer timer_u (
    .clk_i, .reset_i, .sel_i(tmr_sel), .we_i(reg_we), .off_i(reg_off),
    .wdata_i(reg_wdata), .be_i(reg_be), .rdata_o(tmr_rdata), .intr_o(tmr_intr)
  );

  periph_intc intc_u (
    .clk_i, .reset_i, .sel_i(intc_sel), .we_i(reg_we), .off_i(reg_off),
    .wdata_i(reg_wdata), .be_i(reg_be), .rdata_o(intc_rdata),
    .src_i(intr_src), .irq_o, .msip_o
  );

endmodule

`default_nettype wire

//--- bench/periph_checker.sv
/*
  Bus response checker: verifies read-valid latency against accepted
  requests and compares returned data with values queued by the bench
*/
`default_nettype none

module periph_checker (
  input wire        clk_i,
  input wire        reset_i,
  input wire        req_i,
  input wire        gnt_i,
  input wire        rvalid_i,
  input wire [31:0] rdata_i
);

  int          err_count = 0;
  logic [31:0] exp_q[$];
  logic [31:0] mask_q[$];
  logic [31:0] exp_v;
  logic [31:0] mask_v;
  logic        acc_d0;
  logic        acc_d1;

  task automatic push_expected(input logic [31:0] exp, input logic [31:0] mask);
    exp_q.push_back(exp);
    mask_q.push_back(mask);
  endtask

  task automatic compare(input string sig, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("FAILED %s expected %h got %h", sig, exp, got);
      err_count++;
    end
  endtask

  task automatic note_error(input string msg);
    $display("error: %s", msg);
    err_count++;
  endtask

  // rvalid must follow the accepting edge by exactly two edges
  always @(posedge clk_i) begin
    if (reset_i) begin
      acc_d0 <= 1'b0;
      acc_d1 <= 1'b0;
    end else begin
      if (rvalid_i !== acc_d1) begin
        note_error("rvalid_o did not arrive two edges after the accepted request");
      end
      acc_d1 <= acc_d0;
      acc_d0 <= req_i && gnt_i;
      if (rvalid_i) begin
        if (exp_q.size() == 0) begin
          note_error("response arrived with no access outstanding");
        end else begin
          exp_v  = exp_q.pop_front();
          mask_v = mask_q.pop_front();
          if (((rdata_i ^ exp_v) & mask_v) !== 32'h0) begin
            $display("FAILED rdata_o expected %h got %h", exp_v, rdata_i);
            err_count++;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/peripheral_subsystem_tb.sv
/*
  Peripheral subsystem testbench: random register traffic, interrupt
  sources and timer run checked against a register model
*/
`default_nettype none
`include "periph_defines.svh"

module peripheral_subsystem_tb;

  localparam int LIMIT = 16 + 200 * 6 + 2000;

  logic        clk_i = 1'b0;
  logic        reset_i;
  logic        req_i;
  logic [31:0] addr_i;
  logic        we_i;
  logic [3:0]  be_i;
  logic [31:0] wdata_i;
  logic [`PERIPH_GPIO_W-1:0]   gpio_i;
  logic [`PERIPH_NEXT_INT-1:0] ext_intr_i;
  wire         gnt_o;
  wire         rvalid_o;
  wire  [31:0] rdata_o;
  wire  [`PERIPH_GPIO_W-1:0]   gpio_o;
  wire  [`PERIPH_GPIO_W-1:0]   gpio_oe_o;
  wire         irq_o;
  wire         msip_o;

  logic [31:0] lfsr_q = 32'h5196;
  int          cycles = 0;
  int          tests = 0;
  int          failed = 0;
  int          err_mark = 0;

  // Register model
  logic [15:0] m_out = '0;
  logic [15:0] m_oen = '0;
  logic [15:0] m_ien = '0;
  logic [31:0] m_cmp = '0;
  logic [31:0] m_en = '0;
  logic        m_msip = 1'b0;

  logic [31:0] data;
  logic [31:0] got;
  logic [31:0] exp_pend;
  logic [31:0] rw_addr;
  logic [31:0] exp_data;
  logic [3:0]  be;
  logic [2:0]  sel;
  logic [15:0] pins;
  logic [15:0] mask;
  logic [7:0]  ext;
  logic [5:0]  cmp;

  peripheral_subsystem uut (
    .clk_i, .reset_i, .req_i, .addr_i, .we_i, .be_i, .wdata_i,
    .gnt_o, .rvalid_o, .rdata_o, .gpio_i, .gpio_o, .gpio_oe_o,
    .ext_intr_i, .irq_o, .msip_o
  );

  periph_checker chk (
    .clk_i, .reset_i, .req_i, .gnt_i(gnt_o), .rvalid_i(rvalid_o), .rdata_i(rdata_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [3:0] blk, input logic [1:0] off);
    return {`PERIPH_BASE_HI, blk, 8'h00, off, 2'b00};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                              input logic [3:0] b_en);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (b_en[b]) r[8*b +: 8] = nw[8*b +: 8];
    end
    return r;
  endfunction

  task automatic bus_access(input logic [31:0] addr, input logic we, input logic [3:0] b_en,
                            input logic [31:0] wdata, input logic [31:0] exp,
                            input logic [31:0] exp_mask, output logic [31:0] rd);
    chk.push_expected(exp, exp_mask);
    req_i   = 1'b1;
    addr_i  = addr;
    we_i    = we;
    be_i    = b_en;
    wdata_i = wdata;
    @(negedge clk_i);
    while (!gnt_o) @(negedge clk_i);
    @(posedge clk_i);
    #1 req_i = 1'b0;
    we_i = 1'b0;
    @(negedge clk_i);
    while (!rvalid_o) @(negedge clk_i);
    rd = rdata_o;
    @(posedge clk_i);
    #1;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] b_en,
                           input logic [31:0] wdata);
    logic [31:0] unused;
    bus_access(addr, 1'b1, b_en, wdata, 32'h0, '1, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] unused;
    bus_access(addr, 1'b0, 4'hf, 32'h0, exp, '1, unused);
  endtask

  task automatic bus_peek(input logic [31:0] addr, output logic [31:0] rd);
    bus_access(addr, 1'b0, 4'hf, 32'h0, 32'h0, 32'h0, rd);
  endtask

  task automatic check_outputs(input logic exp_irq);
    chk.compare("gpio_o", 32'(m_out), 32'(gpio_o));
    chk.compare("gpio_oe_o", 32'(m_oen), 32'(gpio_oe_o));
    chk.compare("msip_o", 32'(m_msip), 32'(msip_o));
    chk.compare("irq_o", 32'(exp_irq), 32'(irq_o));
  endtask

  task automatic check_model_regs();
    bus_read(reg_addr(4'd0, 2'd1), 32'(m_out));
    bus_read(reg_addr(4'd0, 2'd2), 32'(m_oen));
    bus_read(reg_addr(4'd0, 2'd3), 32'(m_ien));
    bus_read(reg_addr(4'd1, 2'd1), m_cmp);
    bus_read(reg_addr(4'd2, 2'd1), m_en);
    bus_read(reg_addr(4'd2, 2'd3), 32'(m_msip));
  endtask

  task automatic wait_irq(input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!irq_o && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (!irq_o) chk.note_error({what, " did not raise irq_o in time"});
    @(posedge clk_i);
    #1;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (chk.err_count != err_mark) begin
      failed++;
      $display("test %s: fail (%0d errors)", name, chk.err_count - err_mark);
    end else begin
      $display("test %s: ok", name);
    end
    err_mark = chk.err_count;
  endtask

  initial begin
    reset_i    = 1'b1;
    req_i      = 1'b0;
    addr_i     = '0;
    we_i       = 1'b0;
    be_i       = '0;
    wdata_i    = '0;
    gpio_i     = '0;
    ext_intr_i = '0;
    repeat (16) @(posedge clk_i);
    #1 reset_i = 1'b0;

    chk.compare("gnt_o", 32'h0, 32'(gnt_o));
    chk.compare("rvalid_o", 32'h0, 32'(rvalid_o));
    check_outputs(1'b0);
    for (int blk = 0; blk < 3; blk++) begin
      for (int off = 0; off < 4; off++) bus_read(reg_addr(4'(blk), 2'(off)), 32'h0);
    end
    finish_test("reset");

    repeat (200) begin
      sel  = 3'(rand_bits(3) % 6);
      data = rand_bits(32);
      be   = 4'(rand_bits(4));
      case (sel)
        3'd0:    rw_addr = reg_addr(4'd0, 2'd1);
        3'd1:    rw_addr = reg_addr(4'd0, 2'd2);
        3'd2:    rw_addr = reg_addr(4'd0, 2'd3);
        3'd3:    rw_addr = reg_addr(4'd1, 2'd1);
        3'd4:    rw_addr = reg_addr(4'd2, 2'd1);
        default: rw_addr = reg_addr(4'd2, 2'd3);
      endcase
      bus_write(rw_addr, be, data);
      case (sel)
        3'd0:    m_out = 16'(merge_bytes(32'(m_out), data, be));
        3'd1:    m_oen = 16'(merge_bytes(32'(m_oen), data, be));
        3'd2:    m_ien = 16'(merge_bytes(32'(m_ien), data, be));
        3'd3:    m_cmp = merge_bytes(m_cmp, data, be);
        3'd4:    m_en = merge_bytes(m_en, data, be);
        default: m_msip = be[0] ? data[0] : m_msip;
      endcase
      case (sel)
        3'd0:    exp_data = 32'(m_out);
        3'd1:    exp_data = 32'(m_oen);
        3'd2:    exp_data = 32'(m_ien);
        3'd3:    exp_data = m_cmp;
        3'd4:    exp_data = m_en;
        default: exp_data = 32'(m_msip);
      endcase
      bus_read(rw_addr, exp_data);
      check_outputs(1'b0);
    end
    finish_test("random registers");

    // Unmapped offset, windows and upper half
    bus_read(reg_addr(4'd1, 2'd3), 32'h0);
    bus_read(reg_addr(4'd3, 2'd1), 32'h0);
    bus_read(reg_addr(4'hf, 2'd2), 32'h0);
    bus_read(32'h3000_0004, 32'h0);
    bus_write(reg_addr(4'd1, 2'd3), 4'hf, rand_bits(32));
    bus_write(reg_addr(4'd3, 2'd1), 4'hf, rand_bits(32));
    bus_write(reg_addr(4'hf, 2'd2), 4'hf, rand_bits(32));
    bus_write(32'h3000_0004, 4'hf, rand_bits(32));
    check_model_regs();
    // Timer still idle and nothing pending
    bus_read(reg_addr(4'd1, 2'd0), 32'h0);
    bus_read(reg_addr(4'd1, 2'd2), 32'h0);
    bus_read(reg_addr(4'd2, 2'd0), 32'h0);
    check_outputs(1'b0);
    finish_test("unmapped");

    mask = 16'(rand_bits(16)) | 16'h0001;
    pins = 16'(rand_bits(16)) | 16'h0001;
    bus_write(reg_addr(4'd0, 2'd3), 4'hf, 32'(mask));
    m_ien = mask;
    m_en  = 32'(mask) << `PERIPH_SRC_GPIO;
    bus_write(reg_addr(4'd2, 2'd1), 4'hf, m_en);
    gpio_i = pins;
    wait_irq(4, "gpio edge");
    exp_pend = 32'(pins & mask) << `PERIPH_SRC_GPIO;
    bus_read(reg_addr(4'd2, 2'd0), exp_pend);
    for (int i = 1; i < `PERIPH_NSRC; i++) begin
      if (exp_pend[i]) bus_read(reg_addr(4'd2, 2'd2), 32'(i));
    end
    bus_read(reg_addr(4'd2, 2'd2), 32'h0);
    chk.compare("irq_o", 32'h0, 32'(irq_o));
    gpio_i = '0;
    finish_test("gpio interrupts");

    cmp   = 6'(rand_bits(6));
    m_en  = 32'h1 << `PERIPH_SRC_TIMER;
    m_cmp = 32'(cmp);
    bus_write(reg_addr(4'd2, 2'd1), 4'hf, m_en);
    bus_write(reg_addr(4'd1, 2'd1), 4'hf, m_cmp);
    bus_write(reg_addr(4'd1, 2'd2), 4'hf, 32'h1);
    wait_irq(int'(cmp) + 3, "timer match");
    bus_read(reg_addr(4'd2, 2'd0), 32'h1 << `PERIPH_SRC_TIMER);
    bus_peek(reg_addr(4'd1, 2'd0), got);
    if (got > m_cmp) chk.note_error("timer count ran past the compare value");
    bus_write(reg_addr(4'd1, 2'd2), 4'hf, 32'h0);
    finish_test("timer");

    // Timer pending stays set and competes with the external lines
    ext  = 8'(rand_bits(8)) | 8'h01;
    m_en = (32'hff << `PERIPH_SRC_EXT) | (32'h1 << `PERIPH_SRC_TIMER);
    bus_write(reg_addr(4'd2, 2'd1), 4'hf, m_en);
    ext_intr_i = ext;
    repeat (3) @(posedge clk_i);
    #1;
    bus_read(reg_addr(4'd2, 2'd0), (32'(ext) << `PERIPH_SRC_EXT) | (32'h1 << `PERIPH_SRC_TIMER));
    bus_read(reg_addr(4'd2, 2'd2), 32'(`PERIPH_SRC_TIMER));
    for (int i = 0; i < `PERIPH_NEXT_INT; i++) begin
      if (ext[i]) bus_read(reg_addr(4'd2, 2'd2), 32'(`PERIPH_SRC_EXT + i));
    end
    bus_read(reg_addr(4'd2, 2'd2), 32'h0);
    chk.compare("irq_o", 32'h0, 32'(irq_o));
    ext_intr_i = '0;
    finish_test("external lines");

    if (chk.exp_q.size() != 0) chk.note_error("responses missing at end of run");
    $display("tests %0d, failed %0d, errors %0d", tests, failed, chk.err_count);
    if (failed == 0 && chk.err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- peripheral_subsystem.f
+incdir+hdl
hdl/periph_pkg.sv
hdl/periph_bus_ctrl.sv
hdl/periph_gpio.sv
hdl/periph_timer.sv
hdl/periph_intc.sv
hdl/peripheral_subsystem.sv
bench/periph_checker.sv
bench/peripheral_subsystem_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message appears
verilator --binary --timing --assert -Wno-fatal -f peripheral_subsystem.f \
  --top-module peripheral_subsystem_tb -o sim_tb &&
  ./obj_dir/sim_tb | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
  echo "run passed" ||
  { echo "run failed"; exit 1; }
